// ==== filelist.f ====
verilog/i3c_target_pkg.sv
verilog/i3c_bus_monitor.sv
verilog/i3c_rx_framer.sv
verilog/i3c_rx_fifo.sv
verilog/i3c_rx_descriptor.sv
verilog/i3c_target_rx_top.sv
tb/tb_clk_gen.sv
tb/i3c_target_rx_sva.sv
tb/tb_i3c_target_rx.sv

// ==== Bender.yml ====
package:
  name: i3c_target_rx

sources:
  - verilog/i3c_target_pkg.sv
  - verilog/i3c_bus_monitor.sv
  - verilog/i3c_rx_framer.sv
  - verilog/i3c_rx_fifo.sv
  - verilog/i3c_rx_descriptor.sv
  - verilog/i3c_target_rx_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/i3c_target_rx_sva.sv
      - tb/tb_i3c_target_rx.sv

// ==== tb/tb_i3c_target_rx.sv ====
// Testbench top that plays a table of I3C transfers into the target RX path and checks its queues
`timescale 1ns/1ps

module tb_i3c_target_rx
  import i3c_target_pkg::*;
;

  localparam int DriveDelay = 10;
  localparam int HalfScl = 8;
  localparam int NumRows = 10;
  localparam int ShortStallBytes = 2;
  localparam int DescWaitLimit = 400;
  localparam int StallNone = 0;
  localparam int StallShort = 1;
  localparam int StallWhole = 2;
  localparam logic [AddrWidth-1:0] DynAddr = 7'h2A;
  localparam logic [AddrWidth-1:0] StaAddr = 7'h15;

  typedef struct {
    logic [AddrWidth-1:0] addr;
    logic                 rnw;
    int                   count;
    logic                 corrupt;
    int                   stall;
    logic                 end_sr;
    logic                 ack;
  } xfer_row_t;

  logic clk;
  logic rst_n;
  logic scl;
  logic sda_drv;
  logic sda_bus;
  logic standby_en;
  logic [AddrWidth-1:0] sta_addr;
  logic [AddrWidth-1:0] dyn_addr;
  logic sta_valid;
  logic dyn_valid;
  logic rx_queue_full;
  logic sda_out;
  logic bus_start;
  logic bus_rstart;
  logic bus_stop;
  bus_byte_u bus_addr;
  logic bus_addr_valid;
  logic q_wvalid;
  logic [ByteWidth-1:0] q_wdata;
  logic d_wvalid;
  logic [RxDescWidth-1:0] d_wdata;

  xfer_row_t rows [NumRows];
  logic [ByteWidth-1:0] payload [$];
  logic [ByteWidth-1:0] exp_bytes [$];
  logic [RxDescWidth-1:0] exp_descs [$];
  bus_byte_u exp_addrs [$];
  int byte_errs, desc_errs, ack_errs, addr_errs, other_errs;
  int desc_target, desc_seen;
  int start_seen, rstart_seen, stop_seen, exp_start, exp_rstart, exp_stop;
  logic bus_free;
  bit table_ready;

  // Open-drain bus where the target pulls low for the ACK
  assign sda_bus = sda_drv & sda_out;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i3c_target_rx_top dut (
    .clk_i                   (clk),
    .rst_ni                  (rst_n),
    .i3c_standby_en_i        (standby_en),
    .ctrl_scl_i              (scl),
    .ctrl_sda_i              (sda_bus),
    .target_sta_addr_i       (sta_addr),
    .target_sta_addr_valid_i (sta_valid),
    .target_dyn_addr_i       (dyn_addr),
    .target_dyn_addr_valid_i (dyn_valid),
    .rx_queue_full_i         (rx_queue_full),
    .ctrl_sda_o              (sda_out),
    .bus_start_o             (bus_start),
    .bus_rstart_o            (bus_rstart),
    .bus_stop_o              (bus_stop),
    .bus_addr_o              (bus_addr),
    .bus_addr_valid_o        (bus_addr_valid),
    .rx_queue_wvalid_o       (q_wvalid),
    .rx_queue_wdata_o        (q_wdata),
    .rx_desc_queue_wvalid_o  (d_wvalid),
    .rx_desc_queue_wdata_o   (d_wdata)
  );

  task automatic load_table();
    rows[0] = '{DynAddr, 1'b0, 3, 1'b0, StallNone, 1'b0, 1'b1};
    rows[1] = '{DynAddr, 1'b0, 2, 1'b1, StallNone, 1'b1, 1'b1};
    rows[2] = '{DynAddr, 1'b0, 4, 1'b0, StallNone, 1'b1, 1'b1};
    rows[3] = '{StaAddr, 1'b0, 2, 1'b0, StallNone, 1'b0, 1'b0};
    rows[4] = '{7'h33, 1'b0, 1, 1'b0, StallNone, 1'b0, 1'b0};
    rows[5] = '{DynAddr, 1'b1, 1, 1'b0, StallNone, 1'b1, 1'b0};
    rows[6] = '{DynAddr, 1'b0, 5, 1'b0, StallShort, 1'b0, 1'b1};
    rows[7] = '{DynAddr, 1'b0, 7, 1'b0, StallWhole, 1'b1, 1'b1};
    rows[8] = '{DynAddr, 1'b0, 3, 1'b0, StallNone, 1'b0, 1'b1};
    rows[9] = '{DynAddr, 1'b0, 0, 1'b0, StallNone, 1'b0, 1'b1};
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #DriveDelay;
  endtask

  // SDA changes two clocks into the SCL low phase
  task automatic send_bit(input logic b);
    wait_clks(2);
    sda_drv = b;
    wait_clks(HalfScl - 2);
    scl = 1'b1;
    wait_clks(HalfScl);
    scl = 1'b0;
  endtask

  task automatic send_byte(input logic [ByteWidth-1:0] b);
    for (int i = ByteWidth - 1; i >= 0; i--) begin
      send_bit(b[i]);
    end
  endtask

  task automatic sample_ack(output logic acked);
    wait_clks(2);
    sda_drv = 1'b1;
    wait_clks(HalfScl - 2);
    scl = 1'b1;
    wait_clks(HalfScl / 2);
    acked = ~sda_bus;
    wait_clks(HalfScl / 2);
    scl = 1'b0;
  endtask

  // Repeated START leaves SCL high and SDA low, STOP leaves both high
  task automatic send_end(input logic rstart);
    wait_clks(2);
    sda_drv = rstart;
    wait_clks(HalfScl - 2);
    scl = 1'b1;
    wait_clks(HalfScl / 2);
    sda_drv = ~rstart;
    wait_clks(HalfScl / 2);
  endtask

  task automatic check_byte(input logic [ByteWidth-1:0] got, input logic [ByteWidth-1:0] exp);
    if (got !== exp) begin
      byte_errs++;
      $display("FAILED rx_queue_wdata_o: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_desc(input logic [RxDescWidth-1:0] got,
                            input logic [RxDescWidth-1:0] exp);
    if (got !== exp) begin
      desc_errs++;
      $display("FAILED rx_desc_queue_wdata_o: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_ack(input logic got, input logic exp);
    if (got !== exp) begin
      ack_errs++;
      $display("FAILED ctrl_sda_o ACK: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_addr(input bus_byte_u got, input bus_byte_u exp);
    if (got.data !== exp.data) begin
      addr_errs++;
      $display("FAILED bus_addr_o: got 0x%h expected 0x%h", got.data, exp.data);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      other_errs++;
      $display("FAILED %s pulse count: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic predict_row(input int r);
    bus_byte_u header;
    logic [RxDescWidth-1:0] desc;
    logic ovf;
    int kept;
    header.hdr.addr = rows[r].addr;
    header.hdr.rnw  = rows[r].rnw;
    exp_addrs.push_back(header);
    if (rows[r].ack && payload.size() > 0) begin
      // A stalled queue keeps the FIFO contents plus the byte held in the framer
      ovf = rows[r].stall == StallWhole && payload.size() > RxFifoDepth + 1;
      kept = 0;
      foreach (payload[i]) begin
        if (!ovf || i < RxFifoDepth || i == payload.size() - 1) begin
          exp_bytes.push_back(payload[i]);
          kept++;
        end
      end
      desc = '0;
      desc[DescCountWidth-1:0] = DescCountWidth'(kept);
      desc[DescParityErrBit] = rows[r].corrupt;
      desc[DescOverflowErrBit] = ovf;
      exp_descs.push_back(desc);
      desc_target++;
    end
  endtask

  task automatic play_row(input int r);
    logic acked;
    logic tbit;
    int waited;
    if (bus_free) begin
      sda_drv = 1'b0;
      exp_start++;
    end
    if (rows[r].stall != StallNone) begin
      rx_queue_full = 1'b1;
    end
    wait_clks(HalfScl);
    scl = 1'b0;
    send_byte({rows[r].addr, rows[r].rnw});
    sample_ack(acked);
    check_ack(acked, rows[r].ack);
    foreach (payload[i]) begin
      send_byte(payload[i]);
      // Odd parity that is flipped on the last byte when corrupted
      tbit = (~^payload[i]) ^ (rows[r].corrupt && i == payload.size() - 1);
      send_bit(tbit);
      if (rows[r].stall == StallShort && i == ShortStallBytes - 1) begin
        rx_queue_full = 1'b0;
      end
    end
    send_end(rows[r].end_sr);
    if (rows[r].end_sr) begin
      exp_rstart++;
    end else begin
      exp_stop++;
    end
    bus_free = ~rows[r].end_sr;
    wait_clks(4);
    rx_queue_full = 1'b0;
    waited = 0;
    while (desc_seen < desc_target && waited < DescWaitLimit) begin
      wait_clks(1);
      waited++;
    end
    if (desc_seen < desc_target) begin
      other_errs++;
      $display("Descriptor of transfer %0d did not arrive in %0d cycles", r, DescWaitLimit);
    end
  endtask

  // Outputs sampled on the falling edge away from any update
  always @(negedge clk) begin
    if (rst_n) begin
      if (bus_start) begin
        start_seen++;
      end
      if (bus_rstart) begin
        rstart_seen++;
      end
      if (bus_stop) begin
        stop_seen++;
      end
      if (bus_addr_valid) begin
        if (exp_addrs.size() == 0) begin
          other_errs++;
          $display("Header pulse on bus_addr_valid_o that no transfer caused");
        end else begin
          check_addr(bus_addr, exp_addrs.pop_front());
        end
      end
      if (q_wvalid) begin
        if (exp_bytes.size() == 0) begin
          other_errs++;
          $display("Unexpected RX queue write of byte 0x%h", q_wdata);
        end else begin
          check_byte(q_wdata, exp_bytes.pop_front());
        end
      end
      if (d_wvalid) begin
        desc_seen++;
        if (exp_descs.size() == 0) begin
          other_errs++;
          $display("Unexpected RX descriptor 0x%h", d_wdata);
        end else begin
          check_desc(d_wdata, exp_descs.pop_front());
        end
      end
    end
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = 100;
    foreach (rows[r]) begin
      limit += (rows[r].count + 1) * 9 * 2 * HalfScl + 4 * HalfScl + DescWaitLimit;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int total;
    scl = 1'b1;
    sda_drv = 1'b1;
    standby_en = 1'b1;
    sta_addr = StaAddr;
    sta_valid = 1'b1;
    dyn_addr = DynAddr;
    dyn_valid = 1'b1;
    rx_queue_full = 1'b0;
    bus_free = 1'b1;
    void'($urandom(8));
    load_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    wait_clks(4);
    for (int r = 0; r < NumRows; r++) begin
      payload.delete();
      for (int i = 0; i < rows[r].count; i++) begin
        payload.push_back(ByteWidth'($urandom));
      end
      predict_row(r);
      play_row(r);
    end
    wait_clks(16);
    if (exp_bytes.size() != 0 || exp_descs.size() != 0 || exp_addrs.size() != 0) begin
      other_errs++;
      $display("Missing outputs: %0d queue bytes, %0d descriptors, %0d headers never seen",
               exp_bytes.size(), exp_descs.size(), exp_addrs.size());
    end
    check_count("bus_start_o", start_seen, exp_start);
    check_count("bus_rstart_o", rstart_seen, exp_rstart);
    check_count("bus_stop_o", stop_seen, exp_stop);
    total = byte_errs + desc_errs + ack_errs + addr_errs + other_errs +
            int'(dut.u_rx_descriptor.u_rx_sva.fail_cnt);
    $display("Errors: byte %0d, desc %0d, ack %0d, addr %0d, other %0d, assertion %0d",
             byte_errs, desc_errs, ack_errs, addr_errs, other_errs,
             dut.u_rx_descriptor.u_rx_sva.fail_cnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tb/i3c_target_rx_sva.sv ====
// Concurrent checks on the descriptor writer, bound into it by the bind below
`timescale 1ns/1ps

module i3c_target_rx_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic fifo_empty_i,
  input logic fifo_pop_i,
  input logic rx_queue_full_i,
  input logic rx_queue_wvalid_i,
  input logic rx_desc_queue_wvalid_i
);

  int unsigned fail_cnt = 0;

  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fifo_pop_i |-> !fifo_empty_i)
    else begin
      fail_cnt++;
      $error("fifo_pop_o asserted while the FIFO is empty");
    end

  wvalid_not_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rx_queue_wvalid_i |-> !rx_queue_full_i)
    else begin
      fail_cnt++;
      $error("rx_queue_wvalid_o asserted while rx_queue_full_i is high");
    end

  // Descriptor strobe lasts one cycle
  desc_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rx_desc_queue_wvalid_i |=> !rx_desc_queue_wvalid_i)
    else begin
      fail_cnt++;
      $error("rx_desc_queue_wvalid_o held longer than one cycle");
    end

endmodule

bind i3c_rx_descriptor i3c_target_rx_sva u_rx_sva (
  .clk_i                  (clk_i),
  .rst_ni                 (rst_ni),
  .fifo_empty_i           (fifo_empty_i),
  .fifo_pop_i             (fifo_pop_o),
  .rx_queue_full_i        (rx_queue_full_i),
  .rx_queue_wvalid_i      (rx_queue_wvalid_o),
  .rx_desc_queue_wvalid_i (rx_desc_queue_wvalid_o)
);

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int ClkPeriodNs = 100;
  localparam int ResetCycles = 3;
  localparam int ReleaseDelayNs = 10;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset leaves just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #ReleaseDelayNs;
    rst_no = 1'b1;
  end

endmodule

// ==== verilog/i3c_target_rx_top.sv ====
// Top level of the I3C target receive path: bus monitor, framer, byte FIFO and descriptor writer
`timescale 1ns/1ps

module i3c_target_rx_top
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i3c_standby_en_i,
  input  logic                   ctrl_scl_i,
  input  logic                   ctrl_sda_i,
  input  logic [AddrWidth-1:0]   target_sta_addr_i,
  input  logic                   target_sta_addr_valid_i,
  input  logic [AddrWidth-1:0]   target_dyn_addr_i,
  input  logic                   target_dyn_addr_valid_i,
  input  logic                   rx_queue_full_i,
  output logic                   ctrl_sda_o,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output bus_byte_u              bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   rx_queue_wvalid_o,
  output logic [ByteWidth-1:0]   rx_queue_wdata_o,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0] rx_desc_queue_wdata_o
);

  logic scl_posedge;
  logic scl_negedge;
  logic sda_sync;
  logic push;
  logic [ByteWidth-1:0] push_data;
  logic push_last;
  logic [RxErrWidth-1:0] push_err;
  logic fifo_full;
  logic fifo_empty;
  logic [ByteWidth-1:0] fifo_data;
  logic fifo_last;
  logic [RxErrWidth-1:0] fifo_err;
  logic fifo_pop;

  i3c_bus_monitor u_bus_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (i3c_standby_en_i),
    .scl_i         (ctrl_scl_i),
    .sda_i         (ctrl_sda_i),
    .scl_posedge_o (scl_posedge),
    .scl_negedge_o (scl_negedge),
    .start_det_o   (bus_start_o),
    .rstart_det_o  (bus_rstart_o),
    .stop_det_o    (bus_stop_o),
    .sda_o         (sda_sync)
  );

  i3c_rx_framer u_rx_framer (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .scl_posedge_i           (scl_posedge),
    .scl_negedge_i           (scl_negedge),
    .start_det_i             (bus_start_o),
    .rstart_det_i            (bus_rstart_o),
    .stop_det_i              (bus_stop_o),
    .sda_i                   (sda_sync),
    .target_sta_addr_i       (target_sta_addr_i),
    .target_sta_addr_valid_i (target_sta_addr_valid_i),
    .target_dyn_addr_i       (target_dyn_addr_i),
    .target_dyn_addr_valid_i (target_dyn_addr_valid_i),
    .fifo_full_i             (fifo_full),
    .sda_o                   (ctrl_sda_o),
    .bus_addr_o              (bus_addr_o),
    .bus_addr_valid_o        (bus_addr_valid_o),
    .push_o                  (push),
    .push_data_o             (push_data),
    .push_last_o             (push_last),
    .push_err_o              (push_err)
  );

  i3c_rx_fifo u_rx_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_data_i (push_data),
    .push_last_i (push_last),
    .push_err_i  (push_err),
    .pop_i       (fifo_pop),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty),
    .head_data_o (fifo_data),
    .head_last_o (fifo_last),
    .head_err_o  (fifo_err)
  );

  i3c_rx_descriptor u_rx_descriptor (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .fifo_empty_i           (fifo_empty),
    .fifo_data_i            (fifo_data),
    .fifo_last_i            (fifo_last),
    .fifo_err_i             (fifo_err),
    .rx_queue_full_i        (rx_queue_full_i),
    .fifo_pop_o             (fifo_pop),
    .rx_queue_wvalid_o      (rx_queue_wvalid_o),
    .rx_queue_wdata_o       (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o (rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o  (rx_desc_queue_wdata_o)
  );

endmodule

// ==== verilog/i3c_rx_descriptor.sv ====
// Descriptor writer that drains the byte FIFO into the RX queue and closes each transfer
`timescale 1ns/1ps

module i3c_rx_descriptor
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fifo_empty_i,
  input  logic [ByteWidth-1:0]   fifo_data_i,
  input  logic                   fifo_last_i,
  input  logic [RxErrWidth-1:0]  fifo_err_i,
  input  logic                   rx_queue_full_i,
  output logic                   fifo_pop_o,
  output logic                   rx_queue_wvalid_o,
  output logic [ByteWidth-1:0]   rx_queue_wdata_o,
  output logic                   rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0] rx_desc_queue_wdata_o
);

  logic [DescCountWidth-1:0] byte_cnt;
  logic [RxErrWidth-1:0] err_acc;
  logic [RxErrWidth-1:0] err_all;
  logic [RxDescWidth-1:0] desc_next;

  // Bytes stay in the FIFO while the queue is full
  assign fifo_pop_o        = ~fifo_empty_i & ~rx_queue_full_i;
  assign rx_queue_wvalid_o = fifo_pop_o;
  assign rx_queue_wdata_o  = fifo_data_i;

  assign err_all = err_acc | fifo_err_i;

  always_comb begin
    desc_next = '0;
    desc_next[DescCountWidth-1:0] = byte_cnt + 1'b1;
    desc_next[DescParityErrBit] = err_all[ErrParityIdx];
    desc_next[DescOverflowErrBit] = err_all[ErrOverflowIdx];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt               <= '0;
      err_acc                <= '0;
      rx_desc_queue_wvalid_o <= 1'b0;
    end else begin
      rx_desc_queue_wvalid_o <= fifo_pop_o & fifo_last_i;
      if (fifo_pop_o) begin
        if (fifo_last_i) begin
          byte_cnt <= '0;
          err_acc  <= '0;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
          err_acc  <= err_all;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o && fifo_last_i) begin
      rx_desc_queue_wdata_o <= desc_next;
    end
  end

endmodule

// ==== verilog/i3c_rx_fifo.sv ====
// Byte FIFO between framer and descriptor writer that buffers bytes with their last and error flags
`timescale 1ns/1ps

module i3c_rx_fifo
  import i3c_target_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  logic [ByteWidth-1:0]  push_data_i,
  input  logic                  push_last_i,
  input  logic [RxErrWidth-1:0] push_err_i,
  input  logic                  pop_i,
  output logic                  full_o,
  output logic                  empty_o,
  output logic [ByteWidth-1:0]  head_data_o,
  output logic                  head_last_o,
  output logic [RxErrWidth-1:0] head_err_o
);

  logic [ByteWidth-1:0] data_mem [RxFifoDepth];
  logic last_mem [RxFifoDepth];
  logic [RxErrWidth-1:0] err_mem [RxFifoDepth];
  logic [RxFifoPtrWidth-1:0] wr_ptr;
  logic [RxFifoPtrWidth-1:0] rd_ptr;
  logic [RxFifoCntWidth-1:0] count;
  logic do_push;
  logic do_pop;

  assign full_o  = count == RxFifoCntWidth'(RxFifoDepth);
  assign empty_o = count == '0;
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign head_data_o = data_mem[rd_ptr];
  assign head_last_o = last_mem[rd_ptr];
  assign head_err_o  = err_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      data_mem[wr_ptr] <= push_data_i;
      last_mem[wr_ptr] <= push_last_i;
      err_mem[wr_ptr]  <= push_err_i;
    end
  end

  // Power-of-two depth lets the pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/i3c_rx_framer.sv ====
// Receive framer that decodes the header, drives the ACK and pushes checked write bytes
`timescale 1ns/1ps

module i3c_rx_framer
  import i3c_target_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_posedge_i,
  input  logic                  scl_negedge_i,
  input  logic                  start_det_i,
  input  logic                  rstart_det_i,
  input  logic                  stop_det_i,
  input  logic                  sda_i,
  input  logic [AddrWidth-1:0]  target_sta_addr_i,
  input  logic                  target_sta_addr_valid_i,
  input  logic [AddrWidth-1:0]  target_dyn_addr_i,
  input  logic                  target_dyn_addr_valid_i,
  input  logic                  fifo_full_i,
  output logic                  sda_o,
  output bus_byte_u             bus_addr_o,
  output logic                  bus_addr_valid_o,
  output logic                  push_o,
  output logic [ByteWidth-1:0]  push_data_o,
  output logic                  push_last_o,
  output logic [RxErrWidth-1:0] push_err_o
);

  logic [2:0] state;
  logic [BitCntWidth-1:0] bit_cnt;
  logic [ByteWidth-1:0] shift_q;
  bus_byte_u rx_byte;
  logic addr_match;
  logic par_err;
  logic held_valid;
  logic [ByteWidth-1:0] held_data;
  logic fin_pending;
  logic [RxErrWidth-1:0] xfer_err;
  logic [RxErrWidth-1:0] tbit_err;

  assign rx_byte.data = {shift_q[ByteWidth-2:0], sda_i};

  // Static address only counts while no dynamic address is assigned
  always_comb begin
    if (target_dyn_addr_valid_i) begin
      addr_match = rx_byte.hdr.addr == target_dyn_addr_i;
    end else begin
      addr_match = target_sta_addr_valid_i && (rx_byte.hdr.addr == target_sta_addr_i);
    end
  end

  // T-bit is odd parity over the data byte
  assign par_err = ~^{shift_q, sda_i};

  always_comb begin
    tbit_err = xfer_err;
    tbit_err[ErrParityIdx] = xfer_err[ErrParityIdx] | par_err;
    tbit_err[ErrOverflowIdx] = xfer_err[ErrOverflowIdx] | fin_pending |
                               (held_valid & fifo_full_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state            <= StIdle;
      bit_cnt          <= '0;
      sda_o            <= 1'b1;
      bus_addr_o       <= '0;
      bus_addr_valid_o <= 1'b0;
      held_valid       <= 1'b0;
      fin_pending      <= 1'b0;
      xfer_err         <= '0;
      push_o           <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      push_o           <= 1'b0;
      // Last byte of a closed transfer waits here for FIFO space
      if (fin_pending && !fifo_full_i) begin
        push_o      <= 1'b1;
        fin_pending <= 1'b0;
        held_valid  <= 1'b0;
      end
      if ((stop_det_i || rstart_det_i) && held_valid && !fin_pending) begin
        push_data_o <= held_data;
        push_last_o <= 1'b1;
        push_err_o  <= xfer_err;
        if (fifo_full_i) begin
          fin_pending <= 1'b1;
        end else begin
          push_o     <= 1'b1;
          held_valid <= 1'b0;
        end
      end
      if (start_det_i || rstart_det_i || stop_det_i) begin
        state    <= stop_det_i ? StIdle : StHeader;
        bit_cnt  <= '0;
        sda_o    <= 1'b1;
        xfer_err <= '0;
      end else begin
        case (state)
          StHeader: begin
            if (scl_posedge_i) begin
              shift_q <= rx_byte.data;
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == BitCntWidth'(ByteWidth - 1)) begin
                bus_addr_o       <= rx_byte;
                bus_addr_valid_o <= 1'b1;
                state            <= (addr_match && !rx_byte.hdr.rnw) ? StAck : StIdle;
              end
            end
          end
          StAck: begin
            // Pull low on the first falling edge, release on the second
            if (scl_negedge_i) begin
              sda_o <= ~sda_o;
              if (!sda_o) begin
                state <= StData;
              end
            end
          end
          StData: begin
            if (scl_posedge_i) begin
              shift_q <= rx_byte.data;
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == BitCntWidth'(ByteWidth - 1)) begin
                state <= StTbit;
              end
            end
          end
          StTbit: begin
            if (scl_posedge_i) begin
              xfer_err <= tbit_err;
              state    <= StData;
              if (!fin_pending) begin
                held_data  <= shift_q;
                held_valid <= 1'b1;
                if (held_valid && !fifo_full_i) begin
                  push_o      <= 1'b1;
                  push_data_o <= held_data;
                  push_last_o <= 1'b0;
                  push_err_o  <= tbit_err;
                end
              end
            end
          end
          default: state <= StIdle;
        endcase
      end
    end
  end

endmodule

// ==== verilog/i3c_bus_monitor.sv ====
// Bus monitor that synchronizes SCL and SDA and emits edge, START, Sr and STOP pulses
`timescale 1ns/1ps

module i3c_bus_monitor
  import i3c_target_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic start_det_o,
  output logic rstart_det_o,
  output logic stop_det_o,
  output logic sda_o
);

  logic [SyncStages-1:0] scl_sync;
  logic [SyncStages-1:0] sda_sync;
  logic scl_s;
  logic sda_s;
  logic scl_q;
  logic sda_q;
  logic bus_busy;
  logic scl_high;
  logic sda_fall;
  logic sda_rise;

  assign scl_s = scl_sync[SyncStages-1];
  assign sda_s = sda_sync[SyncStages-1];

  // SCL must be high on both samples around the SDA change
  assign scl_high = scl_s & scl_q;
  assign sda_fall = sda_q & ~sda_s;
  assign sda_rise = ~sda_q & sda_s;

  // Delayed SDA lines up with the registered edge pulses
  assign sda_o = sda_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[SyncStages-2:0], scl_i};
      sda_sync <= {sda_sync[SyncStages-2:0], sda_i};
      scl_q    <= scl_s;
      sda_q    <= sda_s;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      start_det_o   <= 1'b0;
      rstart_det_o  <= 1'b0;
      stop_det_o    <= 1'b0;
      bus_busy      <= 1'b0;
    end else begin
      scl_posedge_o <= enable_i & scl_s & ~scl_q;
      scl_negedge_o <= enable_i & ~scl_s & scl_q;
      start_det_o   <= enable_i & scl_high & sda_fall & ~bus_busy;
      rstart_det_o  <= enable_i & scl_high & sda_fall & bus_busy;
      stop_det_o    <= enable_i & scl_high & sda_rise;
      // Busy from START until STOP, tells START from repeated START
      if (!enable_i) begin
        bus_busy <= 1'b0;
      end else if (scl_high && sda_rise) begin
        bus_busy <= 1'b0;
      end else if (scl_high && sda_fall) begin
        bus_busy <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/i3c_target_pkg.sv ====
// Shared constants and the bus byte type of the I3C target receive path, imported by every module
package i3c_target_pkg;

  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BitCntWidth = $clog2(ByteWidth);
  localparam int unsigned RxDescWidth = 32;
  localparam int unsigned SyncStages = 2;

  // Byte FIFO between framer and descriptor writer
  localparam int unsigned RxFifoDepth = 4;
  localparam int unsigned RxFifoPtrWidth = $clog2(RxFifoDepth);
  localparam int unsigned RxFifoCntWidth = $clog2(RxFifoDepth + 1);

  // RX descriptor layout, all other bits are zero
  localparam int unsigned DescCountWidth = 16;
  localparam int unsigned DescParityErrBit = 16;
  localparam int unsigned DescOverflowErrBit = 17;

  // Error flags that travel with every FIFO entry
  localparam int unsigned RxErrWidth = 2;
  localparam int unsigned ErrParityIdx = 0;
  localparam int unsigned ErrOverflowIdx = 1;

  // Framer FSM states
  localparam logic [2:0] StIdle = 3'd0;
  localparam logic [2:0] StHeader = 3'd1;
  localparam logic [2:0] StAck = 3'd2;
  localparam logic [2:0] StData = 3'd3;
  localparam logic [2:0] StTbit = 3'd4;

  // A bus byte is read either as header or as payload
  typedef union packed {
    struct packed {
      logic [AddrWidth-1:0] addr;
      logic                 rnw;
    } hdr;
    logic [ByteWidth-1:0] data;
  } bus_byte_u;

endpackage
